//--- sim.f
source/fetch_pkg.sv
source/fetch_sequencer.sv
source/line_unpacker.sv
source/inst_fifo.sv
source/fetch_unit.sv
test/fetch_unit_properties.sv
test/fetch_unit_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module fetch_unit_tb -f sim.f || exit 1
./obj_dir/Vfetch_unit_tb | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- test/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb import fetch_pkg::*; ();

    localparam logic [31:0] MEM_TAG      = 32'hc0de_0000;  // Word at a is a[31:0] ^ tag
    localparam logic [31:0] LCG_SEED     = 32'hed4;
    localparam int          WAIT_LIMIT   = 20000;          // Cycles per wait loop
    localparam int          TARGET_INSTS = 600;
    localparam int          REDIRECTS    = 6;

    logic              clock;
    logic              reset_n        = 1'b0;
    logic              redirect_valid = 1'b0;
    logic [PC_W-1:0]   redirect_pc    = '0;
    logic              line_req_ready = 1'b0;
    logic              line_rsp_valid = 1'b0;
    logic [LINE_W-1:0] line_rsp_data  = '0;
    logic              inst_ready     = 1'b0;
    logic              line_req_valid;
    logic [PC_W-1:0]   line_req_addr;
    logic              inst_valid;
    logic [INST_W-1:0] inst_data;
    logic [PC_W-1:0]   inst_pc;

    logic [31:0]       lcg_state = LCG_SEED;
    logic              mem_busy  = 1'b0;   // Line accepted and its response pending
    logic [PC_W-1:0]   mem_addr  = '0;
    logic [2:0]        rsp_wait  = '0;     // Cycles left before the response
    logic [PC_W-1:0]   exp_pc;             // Address of the next instruction decode should see
    int                accepted;
    logic              first_req;          // No line request taken yet
    logic              verdict_done      = 1'b0;
    logic              slow_phase;

    fetch_unit u_fetch_unit (
        .clock          (clock),
        .reset_n        (reset_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .line_req_ready (line_req_ready),
        .line_rsp_valid (line_rsp_valid),
        .line_rsp_data  (line_rsp_data),
        .inst_ready     (inst_ready),
        .line_req_valid (line_req_valid),
        .line_req_addr  (line_req_addr),
        .inst_valid     (inst_valid),
        .inst_data      (inst_data),
        .inst_pc        (inst_pc)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Full 64-byte line as the memory returns it
    function automatic logic [LINE_W-1:0] build_line(input logic [PC_W-1:0] addr);
        logic [LINE_W-1:0] line;
        logic [PC_W-1:0]   word_addr;
        for (int k = 0; k < LINE_INSTS; k++) begin
            word_addr = addr + PC_W'(4 * k);
            line[k*INST_W +: INST_W] = word_addr[31:0] ^ MEM_TAG;
        end
        return line;
    endfunction

    // Mid-line jump targets at word offsets 3, 10, 1, 8, 15 and 6
    function automatic logic [PC_W-1:0] redirect_target(input int n);
        return PC_W'(48'h0000_0004_0000) + PC_W'(n) * PC_W'(48'h1_0000)
               + PC_W'(((n * 7 + 3) % 16) * 4);
    endfunction

    task automatic abort_run(input string why);
        verdict_done = 1'b1;
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("FAIL at time %0t: %s", $time, what));
    endtask

    task automatic wait_accepted(input int target);
        int cycles;
        cycles = 0;
        while (accepted < target && cycles <= WAIT_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (cycles > WAIT_LIMIT)
            abort_run($sformatf("Timeout waiting for %0d accepted instructions", target));
    endtask

    task automatic wait_line_in_flight();
        int cycles;
        cycles = 0;
        while (!mem_busy && cycles <= WAIT_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (cycles > WAIT_LIMIT)
            abort_run("Timeout waiting for a line request to be accepted by memory");
    endtask

    assign slow_phase = (accepted >= 150 && accepted < 300) || (accepted >= 420 && accepted < 500);

    // Memory model and random handshakes with one LCG draw per cycle
    always @(posedge clock) begin
        lcg_state = lcg_next(lcg_state);
        if (!reset_n) begin
            line_req_ready <= 1'b0;
            line_rsp_valid <= 1'b0;
            inst_ready     <= 1'b0;
            mem_busy       <= 1'b0;
        end else begin
            line_req_ready <= lcg_state[28];
            if (slow_phase)
                inst_ready <= (lcg_state[23:22] == 2'b00);  // Heavy decode stall
            else
                inst_ready <= (lcg_state[21:20] != 2'b00);
            line_rsp_valid <= 1'b0;                         // Response is a one-cycle pulse
            if (mem_busy) begin
                if (rsp_wait == 3'd0) begin
                    line_rsp_valid <= 1'b1;
                    line_rsp_data  <= build_line(mem_addr);
                    mem_busy       <= 1'b0;
                end else begin
                    rsp_wait <= rsp_wait - 3'd1;
                end
            end else if (line_req_valid && line_req_ready) begin
                mem_busy <= 1'b1;
                mem_addr <= line_req_addr;
                rsp_wait <= 3'(lcg_state[31:29] % 3'd5);   // 1 to 5 cycles to the response
            end
        end
    end

    // Expected-address tracker
    always @(posedge clock) begin
        if (!reset_n) begin
            exp_pc    <= RESET_PC;
            accepted  <= 0;
            first_req <= 1'b1;
        end else begin
            if (inst_valid && inst_ready)
                accepted <= accepted + 1;
            if (redirect_valid)
                exp_pc <= redirect_pc;                  // New path starts at the target
            else if (inst_valid && inst_ready)
                exp_pc <= exp_pc + PC_W'(4);
            if (line_req_valid && line_req_ready)
                first_req <= 1'b0;
        end
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        (line_req_valid && first_req) |-> (line_req_addr == RESET_PC))
        else report_mismatch("first line request is not at the reset address");

    assert property (@(posedge clock) disable iff (!reset_n)
        (inst_valid && inst_ready) |-> (inst_pc == exp_pc))
        else report_mismatch("accepted inst_pc differs from the expected fetch address");

    assert property (@(posedge clock) disable iff (!reset_n)
        (inst_valid && inst_ready) |-> (inst_data == (exp_pc[31:0] ^ MEM_TAG)))
        else report_mismatch("accepted inst_data does not match memory at the expected address");

    initial begin
        repeat (7) @(posedge clock);
        @(negedge clock);
        assert (!line_req_valid && !inst_valid)
            else report_mismatch("line_req_valid or inst_valid high during reset");
        @(posedge clock);
        reset_n <= 1'b1;                                 // Released after 8 cycles
        for (int n = 0; n < REDIRECTS; n++) begin
            wait_accepted(90 * (n + 1));
            if (n % 2 == 0)
                wait_line_in_flight();                   // Old-path line still in memory
            redirect_valid <= 1'b1;
            redirect_pc    <= redirect_target(n);
            @(posedge clock);
            redirect_valid <= 1'b0;
        end
        wait_accepted(TARGET_INSTS);
        @(posedge clock);
        verdict_done = 1'b1;
        $display("RESULT: PASS");
        $finish;
    end

    // Stopped by a bound assertion with no verdict yet
    final begin
        if (!verdict_done)
            $display("RESULT: FAIL");
    end

endmodule

//--- test/fetch_unit_properties.sv
`timescale 1ns/1ps

module fetch_unit_properties import fetch_pkg::*; (
    input logic              clock,
    input logic              reset_n,
    input logic              redirect_valid,
    input logic              line_req_valid,
    input logic              line_req_ready,
    input logic [PC_W-1:0]   line_req_addr,
    input logic              inst_valid,
    input logic              inst_ready,
    input logic [INST_W-1:0] inst_data,
    input logic [PC_W-1:0]   inst_pc
);

    // Stalled request keeps valid and address, a redirect may restart it
    assert property (@(posedge clock) disable iff (!reset_n)
        (line_req_valid && !line_req_ready && !redirect_valid)
            |=> (line_req_valid && $stable(line_req_addr)))
        else $error("Line request dropped or changed address while stalled");

    // Requests are whole 64-byte lines
    assert property (@(posedge clock) disable iff (!reset_n)
        line_req_valid |-> (line_req_addr[5:0] == 6'd0))
        else $error("Line request address not 64-byte aligned");

    // Head of the queue holds under decode back-pressure
    assert property (@(posedge clock) disable iff (!reset_n)
        (inst_valid && !inst_ready && !redirect_valid)
            |=> (inst_valid && $stable(inst_data) && $stable(inst_pc)))
        else $error("Offered instruction changed before it was accepted");

    assert property (@(posedge clock) disable iff (!reset_n)
        redirect_valid |=> !inst_valid)  // Queue empty the cycle after a redirect
        else $error("Queue not empty after redirect");

endmodule

bind fetch_unit fetch_unit_properties u_fetch_unit_properties (
    .clock          (clock),
    .reset_n        (reset_n),
    .redirect_valid (redirect_valid),
    .line_req_valid (line_req_valid),
    .line_req_ready (line_req_ready),
    .line_req_addr  (line_req_addr),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .inst_data      (inst_data),
    .inst_pc        (inst_pc)
);

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              redirect_valid,
    input  logic [PC_W-1:0]   redirect_pc,
    input  logic              line_req_ready,
    input  logic              line_rsp_valid,
    input  logic [LINE_W-1:0] line_rsp_data,
    input  logic              inst_ready,
    output logic              line_req_valid,
    output logic [PC_W-1:0]   line_req_addr,  // 64-byte aligned
    output logic              inst_valid,
    output logic [INST_W-1:0] inst_data,
    output logic [PC_W-1:0]   inst_pc
);

    // Sequencer to unpacker
    logic                line_valid;
    logic [LINE_W-1:0]   line_data;
    logic [PC_W-1:0]     line_base_pc;
    logic [OFFSET_W-1:0] line_offset;
    logic                unpacker_idle;

    // Unpacker to queue
    logic                push;
    logic [INST_W-1:0]   push_inst;
    logic [PC_W-1:0]     push_pc;
    logic                full;
    logic [COUNT_W-1:0]  count;  // Back to the sequencer for refill

    fetch_sequencer u_fetch_sequencer (
        .clock          (clock),
        .reset_n        (reset_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .line_req_ready (line_req_ready),
        .line_rsp_valid (line_rsp_valid),
        .line_rsp_data  (line_rsp_data),
        .unpacker_idle  (unpacker_idle),
        .count          (count),
        .line_req_valid (line_req_valid),
        .line_req_addr  (line_req_addr),
        .line_valid     (line_valid),
        .line_data      (line_data),
        .line_base_pc   (line_base_pc),
        .line_offset    (line_offset)
    );

    line_unpacker u_line_unpacker (
        .clock         (clock),
        .reset_n       (reset_n),
        .flush         (redirect_valid),  // Redirect aborts the line
        .line_valid    (line_valid),
        .line_data     (line_data),
        .line_base_pc  (line_base_pc),
        .line_offset   (line_offset),
        .full          (full),
        .push          (push),
        .push_inst     (push_inst),
        .push_pc       (push_pc),
        .unpacker_idle (unpacker_idle)
    );

    inst_fifo u_inst_fifo (
        .clock      (clock),
        .reset_n    (reset_n),
        .flush      (redirect_valid),     // Redirect empties the queue
        .push       (push),
        .push_inst  (push_inst),
        .push_pc    (push_pc),
        .inst_ready (inst_ready),
        .full       (full),
        .count      (count),
        .inst_valid (inst_valid),
        .inst_data  (inst_data),
        .inst_pc    (inst_pc)
    );

endmodule

//--- source/inst_fifo.sv
`timescale 1ns/1ps

module inst_fifo import fetch_pkg::*; (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               flush,       // Drop everything queued
    input  logic               push,
    input  logic [INST_W-1:0]  push_inst,
    input  logic [PC_W-1:0]    push_pc,
    input  logic               inst_ready,  // Decode takes the head entry
    output logic               full,
    output logic [COUNT_W-1:0] count,
    output logic               inst_valid,
    output logic [INST_W-1:0]  inst_data,
    output logic [PC_W-1:0]    inst_pc
);

    logic [INST_W-1:0] inst_mem [FIFO_DEPTH];
    logic [PC_W-1:0]   pc_mem   [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              do_push;
    logic              do_pop;

    // Depth is not a power of two, so wrap by compare
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (count == COUNT_W'(FIFO_DEPTH));
    assign inst_valid = (count != '0);
    assign do_push    = push && !full;
    assign do_pop     = inst_valid && inst_ready;

    // Show-ahead head entry
    assign inst_data = inst_mem[rd_ptr];
    assign inst_pc   = pc_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            inst_mem[wr_ptr] <= push_inst;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;                     // Empty on the next cycle
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither, level unchanged
            endcase
        end
    end

endmodule

//--- source/line_unpacker.sv
`timescale 1ns/1ps

module line_unpacker import fetch_pkg::*; (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                flush,          // Redirect, abort the current line
    input  logic                line_valid,
    input  logic [LINE_W-1:0]   line_data,
    input  logic [PC_W-1:0]     line_base_pc,
    input  logic [OFFSET_W-1:0] line_offset,    // First word to push
    input  logic                full,
    output logic                push,
    output logic [INST_W-1:0]   push_inst,
    output logic [PC_W-1:0]     push_pc,
    output logic                unpacker_idle
);

    logic [INST_W-1:0]   words [LINE_INSTS];  // Latched line, one slot per instruction
    logic [PC_W-1:0]     base_pc;             // Address of word 0
    logic [OFFSET_W-1:0] index;               // Word being offered to the queue
    logic                busy;
    logic                last;                // Final word of the line

    assign last = (index == OFFSET_W'(LINE_INSTS - 1));

    // Full queue stalls the walk, nothing is dropped
    assign push          = busy && !full;
    assign push_inst     = words[index];
    assign push_pc       = base_pc + PC_W'({index, 2'b00});  // Base plus four per word
    assign unpacker_idle = !busy;

    // Line payload, loaded only on the strobe
    always_ff @(posedge clock) begin
        if (line_valid) begin
            for (int k = 0; k < LINE_INSTS; k++) begin
                words[k] <= line_data[k*INST_W +: INST_W];  // Word k at bits 32k+31:32k
            end
            base_pc <= line_base_pc;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            index <= '0;
        end else if (flush) begin
            busy <= 1'b0;                      // Remaining words belong to the old path
        end else if (line_valid) begin
            busy  <= 1'b1;
            index <= line_offset;              // Skip words before a jump target
        end else if (push) begin
            index <= index + 1'b1;
            if (last)
                busy <= 1'b0;
        end
    end

endmodule

//--- source/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer import fetch_pkg::*; (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                redirect_valid,  // Back end restarts fetch
    input  logic [PC_W-1:0]     redirect_pc,
    input  logic                line_req_ready,
    input  logic                line_rsp_valid,
    input  logic [LINE_W-1:0]   line_rsp_data,
    input  logic                unpacker_idle,
    input  logic [COUNT_W-1:0]  count,           // Queue occupancy
    output logic                line_req_valid,
    output logic [PC_W-1:0]     line_req_addr,
    output logic                line_valid,      // One-cycle load strobe to the unpacker
    output logic [LINE_W-1:0]   line_data,
    output logic [PC_W-1:0]     line_base_pc,
    output logic [OFFSET_W-1:0] line_offset
);

    seq_state_t          state;
    seq_state_t          state_next;
    logic [PC_W-1:0]     fetch_addr;    // Line-aligned address of the next request
    logic [OFFSET_W-1:0] fetch_offset;  // First word to keep from that line
    logic                req_fire;      // Memory took the request this cycle
    logic                rsp_take;      // Response forwarded to the unpacker
    logic                refill_ok;     // Room and an idle unpacker for a new line

    assign req_fire  = line_req_valid && line_req_ready;
    assign rsp_take  = (state == SEQ_WAIT_LINE) && line_rsp_valid && !redirect_valid;
    assign refill_ok = unpacker_idle && (count <= COUNT_W'(REFILL_LEVEL));

    // Request port straight from the state and address registers
    assign line_req_valid = (state == SEQ_REQUEST);
    assign line_req_addr  = fetch_addr;

    // Response passes through in the cycle it arrives
    assign line_valid   = rsp_take;
    assign line_data    = line_rsp_data;
    assign line_base_pc = fetch_addr;     // Still the requested line until the edge
    assign line_offset  = fetch_offset;

    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE: begin
                // Count is stale on a redirect, wait one cycle for the flush
                if (refill_ok && !redirect_valid)
                    state_next = SEQ_REQUEST;
            end
            SEQ_REQUEST: begin
                if (req_fire)
                    state_next = redirect_valid ? SEQ_DISCARD : SEQ_WAIT_LINE;
                // Unaccepted request simply restarts at the new address
            end
            SEQ_WAIT_LINE: begin
                if (line_rsp_valid)
                    state_next = SEQ_IDLE;      // Taken, or dropped on a same-cycle redirect
                else if (redirect_valid)
                    state_next = SEQ_DISCARD;
            end
            SEQ_DISCARD: begin
                if (line_rsp_valid)
                    state_next = SEQ_IDLE;      // Stale line dropped here
            end
            default: state_next = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= SEQ_IDLE;
            fetch_addr   <= RESET_PC & ~PC_W'(LINE_W / 8 - 1);
            fetch_offset <= RESET_PC[OFFSET_W+1:2];
        end else begin
            state <= state_next;
            if (redirect_valid) begin
                // Mid-line target, keep the word index for the unpacker
                fetch_addr   <= redirect_pc & ~PC_W'(LINE_W / 8 - 1);
                fetch_offset <= redirect_pc[OFFSET_W+1:2];
            end else if (rsp_take) begin
                fetch_addr   <= fetch_addr + PC_W'(LINE_W / 8);  // Next sequential line
                fetch_offset <= '0;
            end
        end
    end

endmodule

//--- source/fetch_pkg.sv
package fetch_pkg;

    // Instruction and address widths
    localparam int INST_W     = 32;
    localparam int PC_W       = 48;

    // Memory line geometry, 64 bytes per line
    localparam int LINE_INSTS = 16;
    localparam int LINE_W     = LINE_INSTS * INST_W;  // 512 bits
    localparam int OFFSET_W   = 4;                    // Word index inside a line

    // Instruction queue
    localparam int FIFO_DEPTH   = 24;
    localparam int COUNT_W      = 5;                   // Holds 0..FIFO_DEPTH
    localparam int PTR_W        = $clog2(FIFO_DEPTH);  // Read and write pointers
    localparam int REFILL_LEVEL = 4;                   // Low-water mark for a new line

    localparam logic [PC_W-1:0] RESET_PC = 48'h0000_0000_1000;

    // Fetch request FSM
    typedef enum logic [1:0] {
        SEQ_IDLE,       // Nothing outstanding
        SEQ_REQUEST,    // Request valid, memory not ready yet
        SEQ_WAIT_LINE,  // Request accepted, line not back yet
        SEQ_DISCARD     // Line in flight belongs to the old path
    } seq_state_t;

endpackage
